/* cdc_reset_ctrlr_pkg.sv */
`default_nettype none

package cdc_reset_ctrlr_pkg;

  // ----------------------------------------
  // clear sequence phases
  // ----------------------------------------

  // phase word sent across the domain crossing
  // the receiving side mirrors the last phase it accepted
  typedef enum logic [1:0] {
    // normal operation with isolate and clear both released
    CLEAR_PHASE_IDLE       = 2'd0,
    // side must stop taking and presenting transactions
    CLEAR_PHASE_ISOLATE    = 2'd1,
    // side clears its state while still isolated
    CLEAR_PHASE_CLEAR      = 2'd2,
    // clear released, isolate still held
    CLEAR_PHASE_POST_CLEAR = 2'd3
  } clear_seq_phase_e;

  // ----------------------------------------
  // defaults
  // ----------------------------------------

  // synchronizer depth for the req and ack crossings
  localparam int unsigned DEFAULT_SYNC_STAGES = 2;

endpackage

`default_nettype wire

/* cdc_4phase_src.sv */
`default_nettype none

module cdc_4phase_src
  import cdc_reset_ctrlr_pkg::*;
#(
  parameter int unsigned SYNC_STAGES    = DEFAULT_SYNC_STAGES,
  parameter bit          CLEAR_ON_RESET = 1'b1
) (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             clr_i,
  input  wire clear_seq_phase_e data_i,
  input  wire logic             valid_i,
  output logic                  ready_o,
  output logic                  async_req_o,
  output clear_seq_phase_e      async_data_o,
  input  wire logic             async_ack_i
);

  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_WAIT_ACK_HI,
    SRC_WAIT_ACK_LO
  } src_state_e;

  src_state_e             state_q;
  src_state_e             state_d;
  logic                   req_q;
  logic                   req_d;
  logic                   reset_msg_q;
  logic                   capture;
  clear_seq_phase_e       data_q;
  logic [SYNC_STAGES:0]   ack_chain;
  logic [SYNC_STAGES-1:0] ack_sync_q;
  logic                   ack_synced;

  // the ack from the other domain goes through a plain flop chain
  assign ack_chain  = {ack_sync_q, async_ack_i};
  assign ack_synced = ack_sync_q[SYNC_STAGES-1];

  // a pending reset message launches even when nothing is offered
  assign capture = (state_q == SRC_IDLE) && (valid_i || reset_msg_q) && !clr_i;

  always_comb begin
    state_d = state_q;
    req_d   = req_q;
    ready_o = 1'b0;
    case (state_q)
      SRC_IDLE: begin
        if (capture) begin
          req_d   = 1'b1;
          state_d = SRC_WAIT_ACK_HI;
        end
      end
      SRC_WAIT_ACK_HI: begin
        // the item counts as consumed only once the far side acked it
        if (ack_synced) begin
          req_d   = 1'b0;
          ready_o = 1'b1;
          state_d = SRC_WAIT_ACK_LO;
        end
      end
      default: begin
        if (!ack_synced) begin
          state_d = SRC_IDLE;
        end
      end
    endcase
    // a restart drops req and waits for the old ack to return low first
    if (clr_i) begin
      req_d   = 1'b0;
      ready_o = 1'b0;
      state_d = SRC_WAIT_ACK_LO;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= SRC_WAIT_ACK_LO;
      req_q       <= 1'b0;
      reset_msg_q <= CLEAR_ON_RESET;
      ack_sync_q  <= '0;
    end else begin
      state_q    <= state_d;
      req_q      <= req_d;
      ack_sync_q <= ack_chain[SYNC_STAGES-1:0];
      if (capture) begin
        reset_msg_q <= 1'b0;
      end
    end
  end

  // phase word is stable from before req rises until ack is seen
  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_q <= reset_msg_q ? CLEAR_PHASE_ISOLATE : data_i;
    end
  end

  assign async_req_o  = req_q;
  assign async_data_o = data_q;

endmodule

`default_nettype wire

/* cdc_4phase_dst.sv */
`default_nettype none

module cdc_4phase_dst
  import cdc_reset_ctrlr_pkg::*;
#(
  parameter int unsigned SYNC_STAGES = DEFAULT_SYNC_STAGES
) (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             clr_i,
  output clear_seq_phase_e      data_o,
  output logic                  valid_o,
  input  wire logic             ready_i,
  input  wire logic             async_req_i,
  input  wire clear_seq_phase_e async_data_i,
  output logic                  async_ack_o
);

  typedef enum logic [1:0] {
    DST_IDLE,
    DST_VALID,
    DST_WAIT_REQ_LO
  } dst_state_e;

  dst_state_e             state_q;
  dst_state_e             state_d;
  logic                   ack_q;
  logic                   ack_d;
  logic                   req_prev_q;
  logic [SYNC_STAGES:0]   req_chain;
  logic [SYNC_STAGES-1:0] req_sync_q;
  logic                   req_synced;
  logic                   req_rise;
  clear_seq_phase_e       data_q;

  assign req_chain  = {req_sync_q, async_req_i};
  assign req_synced = req_sync_q[SYNC_STAGES-1];
  // req_prev restarts low, so a req already high after a clear counts as new
  assign req_rise   = req_synced && !req_prev_q;

  always_comb begin
    state_d = state_q;
    ack_d   = ack_q;
    case (state_q)
      DST_IDLE: begin
        if (req_rise) begin
          state_d = DST_VALID;
        end
      end
      DST_VALID: begin
        // ack only on acceptance so nothing sits in flight unconsumed
        if (ready_i) begin
          ack_d   = 1'b1;
          state_d = DST_WAIT_REQ_LO;
        end else if (!req_synced) begin
          state_d = DST_IDLE;
        end
      end
      default: begin
        if (!req_synced) begin
          ack_d   = 1'b0;
          state_d = DST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= DST_IDLE;
      ack_q      <= 1'b0;
      req_prev_q <= 1'b0;
      req_sync_q <= '0;
    end else begin
      req_sync_q <= req_chain[SYNC_STAGES-1:0];
      if (clr_i) begin
        state_q    <= DST_IDLE;
        ack_q      <= 1'b0;
        req_prev_q <= 1'b0;
      end else begin
        state_q    <= state_d;
        ack_q      <= ack_d;
        req_prev_q <= req_synced;
      end
    end
  end

  // the far side holds its phase word steady while req is high
  always_ff @(posedge clk_i) begin
    if ((state_q == DST_IDLE) && req_rise) begin
      data_q <= async_data_i;
    end
  end

  assign data_o      = data_q;
  assign valid_o     = (state_q == DST_VALID);
  assign async_ack_o = ack_q;

endmodule

`default_nettype wire

/* clear_initiator.sv */
`default_nettype none

module clear_initiator
  import cdc_reset_ctrlr_pkg::*;
#(
  parameter bit CLEAR_ON_RESET = 1'b1
) (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        clear_i,
  input  wire logic        isolate_ack_i,
  input  wire logic        clear_ack_i,
  output clear_seq_phase_e phase_o,
  output logic             phase_valid_o,
  output logic             isolate_o,
  output logic             clear_o,
  input  wire logic        phase_ready_i
);

  // ----------------------------------------
  // state encoding
  // ----------------------------------------

  // each phase has two wait states so that the local ack and the remote
  // acceptance may arrive in either order
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_ISOLATE,
    ST_WAIT_ISOLATE_PHASE_ACK,
    ST_WAIT_ISOLATE_ACK,
    ST_CLEAR,
    ST_WAIT_CLEAR_PHASE_ACK,
    ST_WAIT_CLEAR_ACK,
    ST_POST_CLEAR,
    ST_FINISHED
  } init_state_e;

  localparam init_state_e RESET_STATE = init_state_e'(CLEAR_ON_RESET ? ST_ISOLATE : ST_IDLE);

  init_state_e state_q;
  init_state_e state_d;
  logic        isolate_d;
  logic        clear_d;

  // ----------------------------------------
  // next state and phase offer
  // ----------------------------------------

  always_comb begin
    state_d       = state_q;
    phase_o       = CLEAR_PHASE_IDLE;
    phase_valid_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        phase_o = CLEAR_PHASE_IDLE;
      end
      ST_ISOLATE: begin
        phase_o       = CLEAR_PHASE_ISOLATE;
        phase_valid_o = 1'b1;
        if (phase_ready_i && isolate_ack_i) begin
          state_d = ST_CLEAR;
        end else if (phase_ready_i) begin
          state_d = ST_WAIT_ISOLATE_ACK;
        end else if (isolate_ack_i) begin
          state_d = ST_WAIT_ISOLATE_PHASE_ACK;
        end
      end
      ST_WAIT_ISOLATE_PHASE_ACK: begin
        phase_o       = CLEAR_PHASE_ISOLATE;
        phase_valid_o = 1'b1;
        if (phase_ready_i) begin
          state_d = ST_CLEAR;
        end
      end
      ST_WAIT_ISOLATE_ACK: begin
        // the other side already took ISOLATE, only our own ack is missing
        phase_o = CLEAR_PHASE_ISOLATE;
        if (isolate_ack_i) begin
          state_d = ST_CLEAR;
        end
      end
      ST_CLEAR: begin
        phase_o       = CLEAR_PHASE_CLEAR;
        phase_valid_o = 1'b1;
        if (phase_ready_i && clear_ack_i) begin
          state_d = ST_POST_CLEAR;
        end else if (phase_ready_i) begin
          state_d = ST_WAIT_CLEAR_ACK;
        end else if (clear_ack_i) begin
          state_d = ST_WAIT_CLEAR_PHASE_ACK;
        end
      end
      ST_WAIT_CLEAR_PHASE_ACK: begin
        phase_o       = CLEAR_PHASE_CLEAR;
        phase_valid_o = 1'b1;
        if (phase_ready_i) begin
          state_d = ST_POST_CLEAR;
        end
      end
      ST_WAIT_CLEAR_ACK: begin
        phase_o = CLEAR_PHASE_CLEAR;
        if (clear_ack_i) begin
          state_d = ST_POST_CLEAR;
        end
      end
      ST_POST_CLEAR: begin
        phase_o       = CLEAR_PHASE_POST_CLEAR;
        phase_valid_o = 1'b1;
        if (phase_ready_i) begin
          state_d = ST_FINISHED;
        end
      end
      ST_FINISHED: begin
        // isolate stays up until the other side has gone back to IDLE
        phase_o       = CLEAR_PHASE_IDLE;
        phase_valid_o = 1'b1;
        if (phase_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_ISOLATE;
      end
    endcase
    // a fresh request restarts the sequence from ISOLATE
    if (clear_i) begin
      state_d = ST_ISOLATE;
    end
  end

  // outputs are registered from the next state so they stay low in reset
  assign isolate_d = (state_d != ST_IDLE);
  assign clear_d   = (state_d == ST_CLEAR) || (state_d == ST_WAIT_CLEAR_PHASE_ACK) ||
                     (state_d == ST_WAIT_CLEAR_ACK);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= RESET_STATE;
      isolate_o <= 1'b0;
      clear_o   <= 1'b0;
    end else begin
      state_q   <= state_d;
      isolate_o <= isolate_d;
      clear_o   <= clear_d;
    end
  end

endmodule

`default_nettype wire

/* clear_receiver.sv */
`default_nettype none

module clear_receiver
  import cdc_reset_ctrlr_pkg::*;
(
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             clear_i,
  input  wire clear_seq_phase_e phase_i,
  input  wire logic             phase_valid_i,
  input  wire logic             isolate_ack_i,
  input  wire logic             clear_ack_i,
  output logic                  phase_ready_o,
  output logic                  isolate_o,
  output logic                  clear_o
);

  clear_seq_phase_e phase_q;
  clear_seq_phase_e shown_phase;

  // a pending phase takes effect at once, before it is accepted
  assign shown_phase = phase_valid_i ? phase_i : phase_q;

  // isolate covers every phase but IDLE and clear only the CLEAR phase
  assign isolate_o = (shown_phase != CLEAR_PHASE_IDLE);
  assign clear_o   = (shown_phase == CLEAR_PHASE_CLEAR);

  always_comb begin
    case (phase_i)
      // ISOLATE is accepted only once this side is really isolated
      CLEAR_PHASE_ISOLATE: begin
        phase_ready_o = isolate_ack_i;
      end
      // likewise CLEAR waits until the state has been cleared
      CLEAR_PHASE_CLEAR: begin
        phase_ready_o = clear_ack_i;
      end
      default: begin
        phase_ready_o = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      phase_q <= CLEAR_PHASE_IDLE;
    end else if (clear_i) begin
      phase_q <= CLEAR_PHASE_IDLE;
    end else if (phase_valid_i && phase_ready_o) begin
      phase_q <= phase_i;
    end
  end

endmodule

`default_nettype wire

/* cdc_reset_ctrlr_half.sv */
`default_nettype none

module cdc_reset_ctrlr_half
  import cdc_reset_ctrlr_pkg::*;
#(
  parameter int unsigned SYNC_STAGES    = DEFAULT_SYNC_STAGES,
  parameter bit          CLEAR_ON_RESET = 1'b1
) (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire logic             clear_i,
  input  wire logic             isolate_ack_i,
  input  wire logic             clear_ack_i,
  output logic                  isolate_o,
  output logic                  clear_o,
  output logic                  async_req_o,
  output clear_seq_phase_e      async_data_o,
  input  wire logic             async_ack_i,
  input  wire logic             async_req_i,
  input  wire clear_seq_phase_e async_data_i,
  output logic                  async_ack_o
);

  clear_seq_phase_e init_phase;
  logic             init_valid;
  logic             init_ready;
  logic             init_isolate;
  logic             init_clear;
  clear_seq_phase_e rcv_phase;
  logic             rcv_valid;
  logic             rcv_ready;
  logic             rcv_isolate;
  logic             rcv_clear;

  // ----------------------------------------
  // outgoing sequence started on this side
  // ----------------------------------------

  clear_initiator #(
    .CLEAR_ON_RESET (CLEAR_ON_RESET)
  ) initiator_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .clear_i       (clear_i),
    .isolate_ack_i (isolate_ack_i),
    .clear_ack_i   (clear_ack_i),
    .phase_o       (init_phase),
    .phase_valid_o (init_valid),
    .isolate_o     (init_isolate),
    .clear_o       (init_clear),
    .phase_ready_i (init_ready)
  );

  cdc_4phase_src #(
    .SYNC_STAGES    (SYNC_STAGES),
    .CLEAR_ON_RESET (CLEAR_ON_RESET)
  ) src_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .clr_i        (clear_i),
    .data_i       (init_phase),
    .valid_i      (init_valid),
    .ready_o      (init_ready),
    .async_req_o  (async_req_o),
    .async_data_o (async_data_o),
    .async_ack_i  (async_ack_i)
  );

  // ----------------------------------------
  // incoming sequence from the other side
  // ----------------------------------------

  cdc_4phase_dst #(
    .SYNC_STAGES (SYNC_STAGES)
  ) dst_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .clr_i        (clear_i),
    .data_o       (rcv_phase),
    .valid_o      (rcv_valid),
    .ready_i      (rcv_ready),
    .async_req_i  (async_req_i),
    .async_data_i (async_data_i),
    .async_ack_o  (async_ack_o)
  );

  clear_receiver receiver_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .clear_i       (clear_i),
    .phase_i       (rcv_phase),
    .phase_valid_i (rcv_valid),
    .isolate_ack_i (isolate_ack_i),
    .clear_ack_i   (clear_ack_i),
    .phase_ready_o (rcv_ready),
    .isolate_o     (rcv_isolate),
    .clear_o       (rcv_clear)
  );

  // both sequences may overlap when the two sides clear at the same time
  // and the OR keeps the stricter of the two in force
  assign isolate_o = init_isolate || rcv_isolate;
  assign clear_o   = init_clear || rcv_clear;

endmodule

`default_nettype wire

/* cdc_reset_ctrlr.sv */
`default_nettype none

module cdc_reset_ctrlr
  import cdc_reset_ctrlr_pkg::*;
#(
  parameter int unsigned SYNC_STAGES    = DEFAULT_SYNC_STAGES,
  parameter bit          CLEAR_ON_RESET = 1'b1
) (
  // side a
  input  wire logic a_clk_i,
  input  wire logic a_rst_i,
  input  wire logic a_clear_i,
  input  wire logic a_isolate_ack_i,
  input  wire logic a_clear_ack_i,
  output logic      a_isolate_o,
  output logic      a_clear_o,
  // side b mirrors side a
  input  wire logic b_clk_i,
  input  wire logic b_rst_i,
  input  wire logic b_clear_i,
  input  wire logic b_isolate_ack_i,
  input  wire logic b_clear_ack_i,
  output logic      b_isolate_o,
  output logic      b_clear_o
);

  // crossing wires named after the direction of their request
  logic             async_a2b_req;
  clear_seq_phase_e async_a2b_data;
  logic             async_b2a_ack;
  logic             async_b2a_req;
  clear_seq_phase_e async_b2a_data;
  logic             async_a2b_ack;

  cdc_reset_ctrlr_half #(
    .SYNC_STAGES    (SYNC_STAGES),
    .CLEAR_ON_RESET (CLEAR_ON_RESET)
  ) half_a_i (
    .clk_i         (a_clk_i),
    .rst_i         (a_rst_i),
    .clear_i       (a_clear_i),
    .isolate_ack_i (a_isolate_ack_i),
    .clear_ack_i   (a_clear_ack_i),
    .isolate_o     (a_isolate_o),
    .clear_o       (a_clear_o),
    .async_req_o   (async_a2b_req),
    .async_data_o  (async_a2b_data),
    .async_ack_i   (async_b2a_ack),
    .async_req_i   (async_b2a_req),
    .async_data_i  (async_b2a_data),
    .async_ack_o   (async_a2b_ack)
  );

  cdc_reset_ctrlr_half #(
    .SYNC_STAGES    (SYNC_STAGES),
    .CLEAR_ON_RESET (CLEAR_ON_RESET)
  ) half_b_i (
    .clk_i         (b_clk_i),
    .rst_i         (b_rst_i),
    .clear_i       (b_clear_i),
    .isolate_ack_i (b_isolate_ack_i),
    .clear_ack_i   (b_clear_ack_i),
    .isolate_o     (b_isolate_o),
    .clear_o       (b_clear_o),
    .async_req_o   (async_b2a_req),
    .async_data_o  (async_b2a_data),
    .async_ack_i   (async_a2b_ack),
    .async_req_i   (async_a2b_req),
    .async_data_i  (async_a2b_data),
    .async_ack_o   (async_b2a_ack)
  );

endmodule

`default_nettype wire

/* tb_cdc_side_model.sv */
`default_nettype none

module tb_cdc_side_model #(
  parameter int unsigned ACK_MAX = 7
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic isolate_i,
  input  wire logic clear_i,
  input  wire logic hold_isolate_i,
  input  wire logic hold_clear_i,
  output logic      isolate_ack_o,
  output logic      clear_ack_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned iso_wait = 0;
  int unsigned clr_wait = 0;
  logic        iso_ack_q = 1'b0;
  logic        clr_ack_q = 1'b0;

  // each ack comes a random number of cycles after its request and
  // stays up until the request drops again
  always @(posedge clk_i) begin
    #1;
    if (rst_i || !isolate_i) begin
      iso_ack_q = 1'b0;
      iso_wait  = $urandom % (ACK_MAX + 1);
    end else if (!iso_ack_q && !hold_isolate_i) begin
      if (iso_wait == 0) begin
        iso_ack_q = 1'b1;
      end else begin
        iso_wait = iso_wait - 1;
      end
    end
    if (rst_i || !clear_i) begin
      clr_ack_q = 1'b0;
      clr_wait  = $urandom % (ACK_MAX + 1);
    end else if (!clr_ack_q && !hold_clear_i) begin
      if (clr_wait == 0) begin
        clr_ack_q = 1'b1;
      end else begin
        clr_wait = clr_wait - 1;
      end
    end
  end

  // a dropped request takes its ack down at once
  assign isolate_ack_o = iso_ack_q && isolate_i;
  assign clear_ack_o   = clr_ack_q && clear_i;

endmodule

`default_nettype wire

/* tb_cdc_reset_ctrlr.sv */
`default_nettype none

module tb_cdc_reset_ctrlr;

  timeunit 1ns;
  timeprecision 100ps;

  // ----------------------------------------
  // timing constants
  // ----------------------------------------

  localparam int unsigned SYNC      = 2;
  localparam int unsigned T_SLOW    = 16;
  localparam int unsigned ACK_MAX   = 7;
  localparam int unsigned HOLD_CYC  = 40;
  localparam int unsigned RESET_CYC = 10;
  localparam int unsigned N_TESTS   = 7;
  // latency bound of one sequence plus four serial acknowledges on the slower side
  localparam int unsigned BOUND_NS  = 20 * T_SLOW + 16 * SYNC * T_SLOW + 4 * ACK_MAX * T_SLOW;
  // a reset test also spends the reset itself before the sequence starts
  localparam int unsigned RESET_LIMIT_NS = BOUND_NS + RESET_CYC * T_SLOW;
  localparam int unsigned LIMIT_NS  = BOUND_NS + HOLD_CYC * T_SLOW;
  localparam int unsigned WATCH_NS  = N_TESTS * LIMIT_NS * 2;

  logic a_clk = 1'b0;
  logic b_clk = 1'b0;
  logic a_rst, b_rst, a_clear, b_clear;
  logic a_iso, a_clr, b_iso, b_clr;
  logic a_iso_ack, a_clr_ack, b_iso_ack, b_clr_ack;
  logic a_hold_iso, a_hold_clr, b_hold_iso, b_hold_clr;
  int   errors = 0;
  int   test_errors;
  int   a_iso_rises = 0;
  int   b_iso_rises = 0;
  int   a_clr_rises = 0;
  int   b_clr_rises = 0;
  int   a_base, b_base, a_cbase, b_cbase;
  logic a_iso_prev = 1'b0;
  logic b_iso_prev = 1'b0;
  logic a_clr_prev = 1'b0;
  logic b_clr_prev = 1'b0;
  time  t0;
  string cur_test = "reset_release";

  always #5 a_clk = ~a_clk;
  always #8 b_clk = ~b_clk;

  cdc_reset_ctrlr #(.SYNC_STAGES(SYNC), .CLEAR_ON_RESET(1'b1)) dut_i (
    .a_clk_i(a_clk), .a_rst_i(a_rst), .a_clear_i(a_clear), .a_isolate_ack_i(a_iso_ack),
    .a_clear_ack_i(a_clr_ack), .a_isolate_o(a_iso), .a_clear_o(a_clr),
    .b_clk_i(b_clk), .b_rst_i(b_rst), .b_clear_i(b_clear), .b_isolate_ack_i(b_iso_ack),
    .b_clear_ack_i(b_clr_ack), .b_isolate_o(b_iso), .b_clear_o(b_clr)
  );

  tb_cdc_side_model #(.ACK_MAX(ACK_MAX)) side_a_i (
    .clk_i(a_clk), .rst_i(a_rst), .isolate_i(a_iso), .clear_i(a_clr),
    .hold_isolate_i(a_hold_iso), .hold_clear_i(a_hold_clr),
    .isolate_ack_o(a_iso_ack), .clear_ack_o(a_clr_ack)
  );

  tb_cdc_side_model #(.ACK_MAX(ACK_MAX)) side_b_i (
    .clk_i(b_clk), .rst_i(b_rst), .isolate_i(b_iso), .clear_i(b_clr),
    .hold_isolate_i(b_hold_iso), .hold_clear_i(b_hold_clr),
    .isolate_ack_o(b_iso_ack), .clear_ack_o(b_clr_ack)
  );

  // rising edges of isolate and clear seen per side
  always @(posedge a_clk) begin
    a_iso_rises = a_iso_rises + (a_iso && !a_iso_prev);
    a_clr_rises = a_clr_rises + (a_clr && !a_clr_prev);
    a_iso_prev  = a_iso;
    a_clr_prev  = a_clr;
  end
  always @(posedge b_clk) begin
    b_iso_rises = b_iso_rises + (b_iso && !b_iso_prev);
    b_clr_rises = b_clr_rises + (b_clr && !b_clr_prev);
    b_iso_prev  = b_iso;
    b_clr_prev  = b_clr;
  end

  // counts a failed check against the running test
  task automatic record_failure(input string expected, input string actual);
    errors++;
    $display("Fail %s: expected %s, actual %s", cur_test, expected, actual);
  endtask

  // ----------------------------------------
  // ordering and lock-step checks
  // ----------------------------------------

  ord_a1: assert property (@(posedge a_clk) disable iff (a_rst) a_clr |-> a_iso)
    else record_failure("a_isolate_o=1 with a_clear_o", "0");
  ord_b1: assert property (@(posedge b_clk) disable iff (b_rst) b_clr |-> b_iso)
    else record_failure("b_isolate_o=1 with b_clear_o", "0");
  ord_a2: assert property (@(posedge a_clk) disable iff (a_rst)
    ($past(a_iso) && !a_iso) |-> !$past(a_clr))
    else record_failure("a_clear_o=0 before isolate fell", "1");
  ord_b2: assert property (@(posedge b_clk) disable iff (b_rst)
    ($past(b_iso) && !b_iso) |-> !$past(b_clr))
    else record_failure("b_clear_o=0 before isolate fell", "1");
  ord_a3: assert property (@(posedge a_clk) disable iff (a_rst) a_clr |-> a_iso_ack)
    else record_failure("a_isolate_ack=1 under a_clear_o", "0");
  ord_b3: assert property (@(posedge b_clk) disable iff (b_rst) b_clr |-> b_iso_ack)
    else record_failure("b_isolate_ack=1 under b_clear_o", "0");
  // the far side may clear only once this side is isolated
  lock_ab: assert property (@(posedge b_clk) disable iff (a_rst || b_rst)
    (a_iso && !a_iso_ack) |-> !b_clr)
    else record_failure("b_clear_o=0 before a isolated", "1");
  lock_ba: assert property (@(posedge a_clk) disable iff (a_rst || b_rst)
    (b_iso && !b_iso_ack) |-> !a_clr)
    else record_failure("a_clear_o=0 before b isolated", "1");
  // isolation holds everywhere until the clearing side has finished
  rel_ab: assert property (@(posedge b_clk) disable iff (a_rst || b_rst)
    (a_clr && !a_clr_ack) |-> b_iso)
    else record_failure("b_isolate_o=1 while a clears", "0");
  rel_ba: assert property (@(posedge a_clk) disable iff (a_rst || b_rst)
    (b_clr && !b_clr_ack) |-> a_iso)
    else record_failure("a_isolate_o=1 while b clears", "0");

  // ----------------------------------------
  // test helpers
  // ----------------------------------------

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = errors;
    a_base      = a_iso_rises;
    b_base      = b_iso_rises;
    a_cbase     = a_clr_rises;
    b_cbase     = b_clr_rises;
    t0          = $time;
  endtask

  task automatic pulse_clear(input bit on_a, input bit on_b);
    fork
      if (on_a) begin
        @(posedge a_clk) #1 a_clear = 1'b1;
        @(posedge a_clk) #1 a_clear = 1'b0;
      end
      if (on_b) begin
        @(posedge b_clk) #1 b_clear = 1'b1;
        @(posedge b_clk) #1 b_clear = 1'b0;
      end
    join
  endtask

  // waits for a sequence on both sides to start and end, then checks counts
  task automatic finish_test(input int unsigned limit_ns);
    bit started;
    started = 1'b0;
    while (!(started && !a_iso && !b_iso) && ($time - t0 < limit_ns)) begin
      @(posedge a_clk);
      started = (a_iso_rises > a_base) && (b_iso_rises > b_base);
    end
    if (!(started && !a_iso && !b_iso)) begin
      errors++;
      $display("%s: both sides did not return to idle within %0d ns", cur_test, limit_ns);
    end
    if (a_iso_rises - a_base != 1 || b_iso_rises - b_base != 1) begin
      errors++;
      $display("Fail %s: expected 1/1 isolate sequences, actual %0d/%0d", cur_test,
               a_iso_rises - a_base, b_iso_rises - b_base);
    end
    if (a_clr_rises == a_cbase || b_clr_rises == b_cbase) begin
      errors++;
      $display("Fail %s: expected clear on both sides, actual %0d/%0d pulses", cur_test,
               a_clr_rises - a_cbase, b_clr_rises - b_cbase);
    end
    $display("test %s finished with %0d errors", cur_test, errors - test_errors);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    void'($urandom(18));
    a_rst = 1'b1;
    b_rst = 1'b1;
    a_clear = 1'b0;
    b_clear = 1'b0;
    {a_hold_iso, a_hold_clr, b_hold_iso, b_hold_clr} = '0;
    // both sides leave reset with a clear sequence of their own
    start_test("reset_release");
    fork
      begin
        repeat (RESET_CYC) @(posedge a_clk);
        #1 a_rst = 1'b0;
      end
      begin
        repeat (RESET_CYC) @(posedge b_clk);
        #1 b_rst = 1'b0;
      end
    join
    finish_test(RESET_LIMIT_NS);
    start_test("clear_from_a");
    pulse_clear(1'b1, 1'b0);
    finish_test(BOUND_NS);
    start_test("clear_from_b");
    pulse_clear(1'b0, 1'b1);
    finish_test(BOUND_NS);
    start_test("clear_both");
    pulse_clear(1'b1, 1'b1);
    finish_test(BOUND_NS);
    start_test("reset_a_only");
    @(posedge a_clk) #1 a_rst = 1'b1;
    repeat (RESET_CYC) @(posedge a_clk);
    #1 a_rst = 1'b0;
    finish_test(RESET_LIMIT_NS);
    start_test("hold_isolate_ack");
    a_hold_iso = 1'b1;
    pulse_clear(1'b0, 1'b1);
    repeat (HOLD_CYC) @(posedge b_clk);
    #1 a_hold_iso = 1'b0;
    finish_test(LIMIT_NS);
    start_test("hold_clear_ack");
    // the side b model samples its hold input 1 ns after its own clock edge
    @(posedge b_clk) b_hold_clr = 1'b1;
    pulse_clear(1'b1, 1'b0);
    repeat (HOLD_CYC) @(posedge b_clk);
    b_hold_clr = 1'b0;
    finish_test(LIMIT_NS);
    $display("tests run %0d, errors %0d", N_TESTS, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCH_NS * 1ns);
    $display("watchdog expired during test %s after %0d ns", cur_test, WATCH_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* cdc_reset_ctrlr.f */
cdc_reset_ctrlr_pkg.sv
cdc_4phase_src.sv
cdc_4phase_dst.sv
clear_initiator.sv
clear_receiver.sv
cdc_reset_ctrlr_half.sv
cdc_reset_ctrlr.sv
tb_cdc_side_model.sv
tb_cdc_reset_ctrlr.sv

/* Bender.yml */
package:
  name: cdc_reset_ctrlr

sources:
  - cdc_reset_ctrlr_pkg.sv
  - cdc_4phase_src.sv
  - cdc_4phase_dst.sv
  - clear_initiator.sv
  - clear_receiver.sv
  - cdc_reset_ctrlr_half.sv
  - cdc_reset_ctrlr.sv
  - target: test
    files:
      - tb_cdc_side_model.sv
      - tb_cdc_reset_ctrlr.sv
